// ==== rtl/branch_pkg.sv ====
// Branch unit shared definitions
// Widths, branch and entry-state encodings, and the packed structs that
// carry operands, issue requests, bus results and resolver answers

package branch_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int XLEN      = 32;
    localparam int ROB_IDX_W = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } branch_type_t;

    // Per-entry state of the reservation station
    typedef enum logic [2:0] {
        EMPTY, RS12_PENDING, RS1_PENDING, RS2_PENDING, EX_REQ, EX_WAIT, COMPLETED
    } rs_state_t;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------
    // Source operand, value only meaningful once ready is set
    typedef struct packed {
        logic     ready;
        rob_idx_t rob_idx;
        xlen_t    value;
    } op_data_t;

    typedef struct packed {
        branch_type_t branch_type;
        op_data_t     rs1;
        op_data_t     rs2;
        xlen_t        imm;
        rob_idx_t     dest_rob_idx;
        xlen_t        curr_pc;
        xlen_t        pred_target;
        logic         pred_taken;
    } issue_req_t;

    // Used for both the snoop input and the result output
    typedef struct packed {
        rob_idx_t rob_idx;
        xlen_t    res_value;
        logic     taken;
        logic     mispredicted;
        logic     except_raised;
    } cdb_data_t;

    // Resolution rule
    //   taken: always for JAL/JALR, else the named rs1/rs2 compare
    //   target: curr_pc + imm, or (rs1 + imm) with bit 0 cleared for JALR
    //   next_pc: target when taken, curr_pc + 4 otherwise
    //   mispredicted: taken != pred_taken, or both taken and target != pred_target
    //   except_raised: taken with target[1:0] != 0
    typedef struct packed {
        logic  taken;
        logic  mispredicted;
        logic  except_raised;
        xlen_t next_pc;
    } resolve_res_t;

endpackage

// ==== rtl/prio_enc.sv ====
// Priority encoder
// Returns the index of the lowest asserted input line, with a flag that
// tells whether any line is asserted at all

`timescale 1ns/100ps

module prio_enc #(
    parameter  int N     = 4,
    localparam int ENC_W = $clog2(N)
) (
    input  logic [N-1:0]     lines_i,
    output logic [ENC_W-1:0] enc_o,
    output logic             valid_o
);

    // Scan downwards so the lowest set line wins
    always_comb begin
        enc_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o = ENC_W'(i);
            end
        end
    end

    assign valid_o = |lines_i;

endmodule

// ==== rtl/branch_rs.sv ====
// Branch reservation station
// Holds branch and jump instructions until their operands arrive from the
// snoop bus, sends ready entries to the resolver, stores the result and
// drives it onto the CDB. One credit goes back per freed entry.

`timescale 1ns/100ps

module branch_rs #(
    parameter  int DEPTH = 4,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,

    // Issue side, credit based
    input  logic                     issue_valid_i,
    input  branch_pkg::issue_req_t   issue_i,
    output logic                     credit_o,

    // Snoop bus and CDB output
    input  logic                     cdb_valid_i,
    input  branch_pkg::cdb_data_t    cdb_data_i,
    input  logic                     cdb_ready_i,
    output logic                     cdb_valid_o,
    output branch_pkg::cdb_data_t    cdb_data_o,

    // Resolver
    output logic                     ex_valid_o,
    output branch_pkg::issue_req_t   ex_req_o,
    output logic [IDX_W-1:0]         ex_idx_o,
    input  logic                     res_valid_i,
    input  logic [IDX_W-1:0]         res_idx_i,
    input  branch_pkg::resolve_res_t res_i
);

    typedef logic [IDX_W-1:0] idx_t;

    // Stored instruction and its result
    typedef struct packed {
        branch_pkg::issue_req_t   req;
        branch_pkg::resolve_res_t res;
    } entry_t;

    entry_t                entry_q [DEPTH];
    branch_pkg::rs_state_t state_q [DEPTH];
    branch_pkg::rs_state_t state_d [DEPTH];

    // Selector inputs
    logic [DEPTH-1:0] empty_lines;
    logic [DEPTH-1:0] ex_lines;
    logic [DEPTH-1:0] cdb_lines;

    idx_t free_idx;
    idx_t ex_idx;
    idx_t cdb_idx;
    logic free_valid;
    logic ex_any;
    logic cdb_any;

    // Per-entry write enables
    logic [DEPTH-1:0] ins_en;
    logic [DEPTH-1:0] rs1_en;
    logic [DEPTH-1:0] rs2_en;
    logic [DEPTH-1:0] res_en;
    logic [DEPTH-1:0] match_rs1;
    logic [DEPTH-1:0] match_rs2;

    logic insert;
    logic remove;
    logic credit_q;

    assign insert = issue_valid_i & free_valid;
    assign remove = cdb_valid_o & cdb_ready_i;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            empty_lines[i] = (state_q[i] == branch_pkg::EMPTY);
            ex_lines[i]    = (state_q[i] == branch_pkg::EX_REQ);
            cdb_lines[i]   = (state_q[i] == branch_pkg::COMPLETED);
            match_rs1[i]   = cdb_valid_i &&
                             (cdb_data_i.rob_idx == entry_q[i].req.rs1.rob_idx);
            match_rs2[i]   = cdb_valid_i &&
                             (cdb_data_i.rob_idx == entry_q[i].req.rs2.rob_idx);
        end
    end

    // ------------------------------------------------------------------
    // Entry FSMs
    // ------------------------------------------------------------------
    // Only one of insert/remove/result/operand can apply to an entry in a
    // given state, which gives the insert > remove > result > operand order
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            state_d[i] = state_q[i];
            ins_en[i]  = 1'b0;
            rs1_en[i]  = 1'b0;
            rs2_en[i]  = 1'b0;
            res_en[i]  = 1'b0;
            case (state_q[i])
                branch_pkg::EMPTY: begin
                    if (insert && free_idx == idx_t'(i)) begin
                        ins_en[i] = 1'b1;
                        case ({issue_i.rs1.ready, issue_i.rs2.ready})
                            2'b11:   state_d[i] = branch_pkg::EX_REQ;
                            2'b01:   state_d[i] = branch_pkg::RS1_PENDING;
                            2'b10:   state_d[i] = branch_pkg::RS2_PENDING;
                            default: state_d[i] = branch_pkg::RS12_PENDING;
                        endcase
                    end
                end
                branch_pkg::RS12_PENDING: begin
                    rs1_en[i] = match_rs1[i];
                    rs2_en[i] = match_rs2[i];
                    if (match_rs1[i] && match_rs2[i]) begin
                        state_d[i] = branch_pkg::EX_REQ;
                    end else if (match_rs1[i]) begin
                        state_d[i] = branch_pkg::RS2_PENDING;
                    end else if (match_rs2[i]) begin
                        state_d[i] = branch_pkg::RS1_PENDING;
                    end
                end
                branch_pkg::RS1_PENDING: begin
                    if (match_rs1[i]) begin
                        rs1_en[i]  = 1'b1;
                        state_d[i] = branch_pkg::EX_REQ;
                    end
                end
                branch_pkg::RS2_PENDING: begin
                    if (match_rs2[i]) begin
                        rs2_en[i]  = 1'b1;
                        state_d[i] = branch_pkg::EX_REQ;
                    end
                end
                branch_pkg::EX_REQ: begin
                    // Resolver always accepts
                    if (ex_idx == idx_t'(i)) begin
                        state_d[i] = branch_pkg::EX_WAIT;
                    end
                end
                branch_pkg::EX_WAIT: begin
                    if (res_valid_i && res_idx_i == idx_t'(i)) begin
                        res_en[i]  = 1'b1;
                        state_d[i] = branch_pkg::COMPLETED;
                    end
                end
                branch_pkg::COMPLETED: begin
                    if (remove && cdb_idx == idx_t'(i)) begin
                        state_d[i] = branch_pkg::EMPTY;
                    end
                end
                default: state_d[i] = branch_pkg::EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= branch_pkg::EMPTY;
            end
        end else if (flush_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= branch_pkg::EMPTY;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= state_d[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // Entry payload
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (ins_en[i]) begin
                entry_q[i].req <= issue_i;
            end
            if (rs1_en[i]) begin
                entry_q[i].req.rs1.value <= cdb_data_i.res_value;
                entry_q[i].req.rs1.ready <= 1'b1;
            end
            if (rs2_en[i]) begin
                entry_q[i].req.rs2.value <= cdb_data_i.res_value;
                entry_q[i].req.rs2.ready <= 1'b1;
            end
            if (res_en[i]) begin
                entry_q[i].res <= res_i;
            end
        end
    end

    // One credit per freed entry, none for a flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= remove & ~flush_i;
        end
    end

    assign credit_o = credit_q;

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign ex_valid_o = ex_any;
    assign ex_idx_o   = ex_idx;
    assign ex_req_o   = entry_q[ex_idx].req;

    assign cdb_valid_o = cdb_any;

    always_comb begin
        cdb_data_o.rob_idx       = entry_q[cdb_idx].req.dest_rob_idx;
        cdb_data_o.res_value     = entry_q[cdb_idx].res.next_pc;
        cdb_data_o.taken         = entry_q[cdb_idx].res.taken;
        cdb_data_o.mispredicted  = entry_q[cdb_idx].res.mispredicted;
        cdb_data_o.except_raised = entry_q[cdb_idx].res.except_raised;
    end

    // Free slot, entry to execute, entry for the CDB
    prio_enc #(.N(DEPTH)) i_free_sel (
        .lines_i (empty_lines),
        .enc_o   (free_idx),
        .valid_o (free_valid)
    );

    prio_enc #(.N(DEPTH)) i_ex_sel (
        .lines_i (ex_lines),
        .enc_o   (ex_idx),
        .valid_o (ex_any)
    );

    prio_enc #(.N(DEPTH)) i_cdb_sel (
        .lines_i (cdb_lines),
        .enc_o   (cdb_idx),
        .valid_o (cdb_any)
    );

endmodule

// ==== rtl/branch_resolver.sv ====
// Branch resolver
// Two-stage pipeline: stage 1 evaluates the condition and the target,
// stage 2 forms next PC, misprediction and misaligned-target exception.
// Results come out two cycles after the request.

`timescale 1ns/100ps

module branch_resolver #(
    parameter  int DEPTH = 4,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     ex_valid_i,
    input  branch_pkg::issue_req_t   ex_req_i,
    input  logic [IDX_W-1:0]         ex_idx_i,
    output logic                     res_valid_o,
    output logic [IDX_W-1:0]         res_idx_o,
    output branch_pkg::resolve_res_t res_o
);

    // Stage 1 payload
    typedef struct packed {
        logic [IDX_W-1:0]  idx;
        logic              taken;
        branch_pkg::xlen_t target;
        branch_pkg::xlen_t curr_pc;
        branch_pkg::xlen_t pred_target;
        logic              pred_taken;
    } s1_t;

    branch_pkg::xlen_t        rs1;
    branch_pkg::xlen_t        rs2;
    branch_pkg::xlen_t        jalr_sum;
    logic                     cond;
    s1_t                      s1_d;
    s1_t                      s1_q;
    logic                     s1_valid_q;
    branch_pkg::resolve_res_t s2_d;
    branch_pkg::resolve_res_t s2_q;
    logic [IDX_W-1:0]         s2_idx_q;
    logic                     s2_valid_q;

    assign rs1 = ex_req_i.rs1.value;
    assign rs2 = ex_req_i.rs2.value;
    assign jalr_sum = rs1 + ex_req_i.imm;

    // ------------------------------------------------------------------
    // Stage 1
    // ------------------------------------------------------------------
    always_comb begin
        case (ex_req_i.branch_type)
            branch_pkg::BEQ:  cond = (rs1 == rs2);
            branch_pkg::BNE:  cond = (rs1 != rs2);
            branch_pkg::BLT:  cond = ($signed(rs1) < $signed(rs2));
            branch_pkg::BGE:  cond = ($signed(rs1) >= $signed(rs2));
            branch_pkg::BLTU: cond = (rs1 < rs2);
            branch_pkg::BGEU: cond = (rs1 >= rs2);
            default:          cond = 1'b1;  // JAL, JALR
        endcase
    end

    always_comb begin
        s1_d.idx         = ex_idx_i;
        s1_d.taken       = cond;
        s1_d.curr_pc     = ex_req_i.curr_pc;
        s1_d.pred_target = ex_req_i.pred_target;
        s1_d.pred_taken  = ex_req_i.pred_taken;
        if (ex_req_i.branch_type == branch_pkg::JALR) begin
            s1_d.target = {jalr_sum[branch_pkg::XLEN-1:1], 1'b0};
        end else begin
            s1_d.target = ex_req_i.curr_pc + ex_req_i.imm;
        end
    end

    // ------------------------------------------------------------------
    // Stage 2
    // ------------------------------------------------------------------
    always_comb begin
        s2_d.taken         = s1_q.taken;
        s2_d.next_pc       = s1_q.taken ? s1_q.target : s1_q.curr_pc + 32'd4;
        s2_d.mispredicted  = (s1_q.taken != s1_q.pred_taken) ||
                             (s1_q.taken && s1_q.target != s1_q.pred_target);
        s2_d.except_raised = s1_q.taken && (s1_q.target[1:0] != 2'b00);
    end

    // Valid bits, cleared by a flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= ex_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_q     <= s1_d;
        s2_q     <= s2_d;
        s2_idx_q <= s1_q.idx;
    end

    assign res_valid_o = s2_valid_q;
    assign res_idx_o   = s2_idx_q;
    assign res_o       = s2_q;

endmodule

// ==== rtl/branch_unit_top.sv ====
// Branch unit top level
// Reservation station feeding the two-stage resolver, with credit-based
// issue, snoop input and valid/ready CDB output

`timescale 1ns/100ps

module branch_unit_top #(
    parameter  int DEPTH = 4,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,

    // Issue side
    input  logic                   issue_valid_i,
    input  branch_pkg::issue_req_t issue_i,
    output logic                   credit_o,

    // Snoop bus and CDB output
    input  logic                   cdb_valid_i,
    input  branch_pkg::cdb_data_t  cdb_data_i,
    input  logic                   cdb_ready_i,
    output logic                   cdb_valid_o,
    output branch_pkg::cdb_data_t  cdb_data_o
);

    // Station to resolver and back
    logic                     ex_valid;
    branch_pkg::issue_req_t   ex_req;
    logic [IDX_W-1:0]         ex_idx;
    logic                     res_valid;
    logic [IDX_W-1:0]         res_idx;
    branch_pkg::resolve_res_t res;

    branch_rs #(.DEPTH(DEPTH)) i_branch_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .credit_o      (credit_o),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_data_i    (cdb_data_i),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_data_o    (cdb_data_o),
        .ex_valid_o    (ex_valid),
        .ex_req_o      (ex_req),
        .ex_idx_o      (ex_idx),
        .res_valid_i   (res_valid),
        .res_idx_i     (res_idx),
        .res_i         (res)
    );

    branch_resolver #(.DEPTH(DEPTH)) i_branch_resolver (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .ex_valid_i  (ex_valid),
        .ex_req_i    (ex_req),
        .ex_idx_i    (ex_idx),
        .res_valid_o (res_valid),
        .res_idx_o   (res_idx),
        .res_o       (res)
    );

endmodule

// ==== verif/branch_ref_model.svh ====
// Branch unit reference model
// Expected resolution of one branch or jump, worked out from the
// resolution rule, and a Galois LFSR step for the random stimulus

`ifndef BRANCH_REF_MODEL_SVH
`define BRANCH_REF_MODEL_SVH

// ----------------------------------------------------------------------
// Resolution reference
// ----------------------------------------------------------------------
function automatic branch_pkg::resolve_res_t resolve_ref(input branch_pkg::issue_req_t req);
    branch_pkg::resolve_res_t res;
    branch_pkg::xlen_t        a;
    branch_pkg::xlen_t        b;
    branch_pkg::xlen_t        target;
    logic                     taken;

    a = req.rs1.value;
    b = req.rs2.value;

    case (req.branch_type)
        branch_pkg::BEQ:  taken = (a == b);
        branch_pkg::BNE:  taken = (a != b);
        branch_pkg::BLT:  taken = ($signed(a) < $signed(b));
        branch_pkg::BGE:  taken = !($signed(a) < $signed(b));
        branch_pkg::BLTU: taken = (a < b);
        branch_pkg::BGEU: taken = !(a < b);
        default:          taken = 1'b1;
    endcase

    // Jumps through a register drop bit 0 of the sum
    if (req.branch_type == branch_pkg::JALR) begin
        target = (a + req.imm) & ~branch_pkg::xlen_t'(1);
    end else begin
        target = req.curr_pc + req.imm;
    end

    res.taken = taken;
    if (taken) begin
        res.next_pc = target;
    end else begin
        res.next_pc = req.curr_pc + 4;
    end

    if (taken != req.pred_taken) begin
        res.mispredicted = 1'b1;
    end else begin
        res.mispredicted = taken && (target != req.pred_target);
    end

    res.except_raised = taken && (target[1:0] != 2'b00);
    return res;
endfunction

// ----------------------------------------------------------------------
// Random source
// ----------------------------------------------------------------------
// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

`endif

// ==== verif/tb_branch_unit.sv ====
// Branch unit testbench
// Random and directed branches through the station and resolver, with a
// credit-counting issuer, snoop broadcasts, CDB back-pressure and flush

`timescale 1ns/100ps

module tb_branch_unit;

    localparam int DEPTH      = 4;
    localparam int WAIT_LIMIT = 200;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   flush;
    logic                   issue_valid;
    branch_pkg::issue_req_t issue;
    logic                   credit;
    logic                   snoop_valid;
    branch_pkg::cdb_data_t  snoop_data;
    logic                   cdb_ready;
    logic                   cdb_valid;
    branch_pkg::cdb_data_t  cdb_data;

    // Issuer and checker state
    branch_pkg::cdb_data_t  expected [int];
    int                     credits;
    int                     mismatch_errors;
    int                     other_errors;
    string                  test_name;
    logic [31:0]            lfsr_state;
    branch_pkg::rob_idx_t   next_tag;
    branch_pkg::rob_idx_t   last_tag;
    logic                   hold_valid;
    logic                   hold_ready;
    logic                   hold_flush;
    branch_pkg::cdb_data_t  hold_data;

    `include "branch_ref_model.svh"

    branch_unit_top #(.DEPTH(DEPTH)) i_branch_unit_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .credit_o      (credit),
        .cdb_valid_i   (snoop_valid),
        .cdb_data_i    (snoop_data),
        .cdb_ready_i   (cdb_ready),
        .cdb_valid_o   (cdb_valid),
        .cdb_data_o    (cdb_data)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic branch_pkg::branch_type_t random_type();
        logic [2:0] code;
        code = rand_bits(3);
        return branch_pkg::branch_type_t'(code);
    endfunction

    // Ready operands; about half the predictions are made correct on purpose
    function automatic branch_pkg::issue_req_t random_req(input branch_pkg::branch_type_t btype);
        branch_pkg::issue_req_t   req;
        branch_pkg::resolve_res_t res;
        logic [12:0]              imm13;
        req = '0;
        req.branch_type = btype;
        req.rs1.ready = 1'b1;
        req.rs1.rob_idx = rand_bits(5);
        req.rs1.value = rand_bits(32);
        req.rs2.ready = 1'b1;
        req.rs2.rob_idx = rand_bits(5);
        req.rs2.value = rand_bits(32);
        if (rand_bits(2) == 0) begin
            req.rs2.value = req.rs1.value;
        end
        imm13 = rand_bits(13);
        if (rand_bits(1)) begin
            imm13[1:0] = 2'b00;
        end
        req.imm = {{19{imm13[12]}}, imm13};
        req.curr_pc = rand_bits(32) & 32'hFFFF_FFFC;
        req.pred_taken = rand_bits(1);
        req.pred_target = rand_bits(32);
        if (rand_bits(1)) begin
            res = resolve_ref(req);
            req.pred_taken = res.taken;
            req.pred_target = res.next_pc;
        end
        return req;
    endfunction

    // Issues req; the expected result comes from resolved, which holds the
    // operand values the entry will end up with
    task automatic issue_one(input branch_pkg::issue_req_t req,
                             input branch_pkg::issue_req_t resolved);
        branch_pkg::resolve_res_t res;
        branch_pkg::cdb_data_t    exp;
        int                       waited;
        waited = 0;
        while (credits == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout waiting for an issue credit in test %s", test_name);
            other_errors++;
        end else begin
            req.dest_rob_idx = next_tag;
            resolved.dest_rob_idx = next_tag;
            last_tag = next_tag;
            next_tag++;
            res = resolve_ref(resolved);
            exp.rob_idx = req.dest_rob_idx;
            exp.res_value = res.next_pc;
            exp.taken = res.taken;
            exp.mispredicted = res.mispredicted;
            exp.except_raised = res.except_raised;
            expected[int'(req.dest_rob_idx)] = exp;
            issue_valid = 1'b1;
            issue = req;
            credits--;
            @(negedge clk);
            issue_valid = 1'b0;
        end
    endtask

    task automatic broadcast(input branch_pkg::rob_idx_t tag, input branch_pkg::xlen_t value);
        snoop_valid = 1'b1;
        snoop_data = '0;
        snoop_data.rob_idx = tag;
        snoop_data.res_value = value;
        @(negedge clk);
        snoop_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic compare_cdb(input string name, input branch_pkg::cdb_data_t exp,
                               input branch_pkg::cdb_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected tag=%0d pc=%h tmx=%b actual tag=%0d pc=%h tmx=%b",
                     name, exp.rob_idx, exp.res_value,
                     {exp.taken, exp.mispredicted, exp.except_raised},
                     act.rob_idx, act.res_value,
                     {act.taken, act.mispredicted, act.except_raised});
            mismatch_errors++;
        end
    endtask

    task automatic compare_credit(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s credits: expected %0d actual %0d", name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic wait_drain(input logic random_ready);
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < WAIT_LIMIT) begin
            if (random_ready) begin
                cdb_ready = rand_bits(1);
            end
            @(negedge clk);
            waited++;
        end
        cdb_ready = 1'b1;
        if (expected.size() != 0) begin
            $display("Timeout waiting for %0d results to drain in test %s",
                     expected.size(), test_name);
            other_errors++;
        end else begin
            // Last credit comes back one cycle after the last handshake
            @(negedge clk);
            compare_credit(test_name, DEPTH, credits);
        end
    endtask

    // Compare process for credit returns, held output and results by tag
    always @(posedge clk) begin
        if (rst_n) begin
            if (credit) begin
                credits++;
                if (credits > DEPTH) begin
                    $display("More credits returned than issued in test %s", test_name);
                    other_errors++;
                end
            end
            if (hold_valid && !hold_ready && !hold_flush) begin
                if (!cdb_valid) begin
                    $display("CDB valid dropped under back-pressure in test %s", test_name);
                    other_errors++;
                end else begin
                    compare_cdb({test_name, " hold"}, hold_data, cdb_data);
                end
            end
            if (cdb_valid && cdb_ready) begin
                if (expected.exists(int'(cdb_data.rob_idx))) begin
                    compare_cdb(test_name, expected[int'(cdb_data.rob_idx)], cdb_data);
                    expected.delete(int'(cdb_data.rob_idx));
                end else begin
                    $display("Unexpected rob_idx %0d on the CDB in test %s",
                             cdb_data.rob_idx, test_name);
                    other_errors++;
                end
            end
            hold_valid = cdb_valid;
            hold_ready = cdb_ready;
            hold_flush = flush;
            hold_data  = cdb_data;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        branch_pkg::issue_req_t req;
        branch_pkg::issue_req_t resolved;
        branch_pkg::rob_idx_t   tag_a;
        branch_pkg::rob_idx_t   tag_b;
        rst_n = 1'b0;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        snoop_valid = 1'b0;
        snoop_data = '0;
        cdb_ready = 1'b1;
        credits = DEPTH;
        mismatch_errors = 0;
        other_errors = 0;
        lfsr_state = 32'hec2c1aea;
        next_tag = '0;
        last_tag = '0;
        hold_valid = 1'b0;
        hold_ready = 1'b1;
        hold_flush = 1'b0;
        hold_data = '0;
        test_name = "reset";
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (cdb_valid || credit) begin
            $display("CDB valid or credit high after reset");
            other_errors++;
        end

        test_name = "random";
        for (int k = 0; k < 48; k++) begin
            req = random_req(random_type());
            issue_one(req, req);
            if (rand_bits(2) == 0) begin
                @(negedge clk);
            end
        end
        wait_drain(1'b0);

        // Mode 0 holds rs1 back, mode 1 rs2, mode 2 both on one tag and
        // mode 3 both on two tags
        test_name = "wakeup";
        for (int mode = 0; mode < 4; mode++) begin
            for (int rep = 0; rep < 3; rep++) begin
                resolved = random_req(random_type());
                tag_a = rand_bits(5);
                tag_b = tag_a ^ 5'h01;
                if (mode == 2) begin
                    resolved.rs2.value = resolved.rs1.value;
                end
                req = resolved;
                if (mode != 1) begin
                    req.rs1.ready = 1'b0;
                    req.rs1.rob_idx = tag_a;
                    req.rs1.value = rand_bits(32);
                end
                if (mode != 0) begin
                    req.rs2.ready = 1'b0;
                    req.rs2.rob_idx = (mode == 3) ? tag_b : tag_a;
                    req.rs2.value = rand_bits(32);
                end
                issue_one(req, resolved);
                repeat (4) broadcast(tag_a ^ 5'h10, rand_bits(32));
                if (!expected.exists(int'(last_tag))) begin
                    $display("Entry %0d completed before its operand tag was broadcast",
                             last_tag);
                    other_errors++;
                end
                if (mode == 1) begin
                    broadcast(tag_a, resolved.rs2.value);
                end else begin
                    broadcast(tag_a, resolved.rs1.value);
                end
                if (mode == 3) begin
                    broadcast(tag_b, resolved.rs2.value);
                end
                wait_drain(1'b0);
            end
        end

        // Misaligned low target bits for the first eight, aligned for the rest
        test_name = "misaligned";
        for (int k = 0; k < 16; k++) begin
            req = random_req(branch_pkg::branch_type_t'(k[2:0]));
            req.rs1.value[1:0] = 2'b00;
            req.imm[1:0] = (k < 8) ? 2'b10 : 2'b00;
            issue_one(req, req);
        end
        wait_drain(1'b0);

        // Fill the station with the CDB stalled, then drain at random
        test_name = "backpressure";
        for (int b = 0; b < 6; b++) begin
            cdb_ready = 1'b0;
            for (int k = 0; k < DEPTH; k++) begin
                req = random_req(random_type());
                issue_one(req, req);
            end
            compare_credit("station full", 0, credits);
            repeat (4) @(negedge clk);
            wait_drain(1'b1);
        end

        // Completed, in the resolver and pending entries all at once
        test_name = "flush";
        cdb_ready = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            req = random_req(random_type());
            resolved = req;
            if (k == 2) begin
                req.rs1.ready = 1'b0;
            end
            issue_one(req, resolved);
        end
        if (!cdb_valid) begin
            $display("No completed entry was present before the flush");
            other_errors++;
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (cdb_valid) begin
            $display("CDB valid still high in the cycle after a flush");
            other_errors++;
        end
        expected.delete();
        credits = DEPTH;
        cdb_ready = 1'b1;
        repeat (8) @(negedge clk);

        test_name = "after_flush";
        for (int k = 0; k < 8; k++) begin
            req = random_req(random_type());
            issue_one(req, req);
        end
        wait_drain(1'b0);

        $display("Error counts: %0d mismatches, %0d other errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
rtl/branch_pkg.sv
rtl/prio_enc.sv
rtl/branch_rs.sv
rtl/branch_resolver.sv
rtl/branch_unit_top.sv
verif/tb_branch_unit.sv
